//--- logic/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // ==================
  // Major opcodes.
  // ==================
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYS    = 7'b1110011;

  // Branch conditions.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ==================
  // Instruction formats.
  // ==================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // One word, six views.
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } inst_u;

endpackage

//--- logic/riscv_ex_pkg.sv
package riscv_ex_pkg;

  localparam int XLEN        = 32;
  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;

  // ==================
  // ALU function codes.
  // ==================
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101,
    ALU_NONE = 4'b1111
  } alu_op_t;

  // Operand sources.
  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } a_sel_t;

  typedef enum logic [1:0] {
    B_RS2,
    B_IMM,
    B_FOUR
  } b_sel_t;

endpackage

//--- logic/riscv_ex_funcode.sv
`timescale 1ns/1ps

module riscv_ex_funcode (
  input  riscv_isa_pkg::inst_u               inst,
  output riscv_ex_pkg::alu_op_t              funcode,
  output riscv_ex_pkg::a_sel_t               a_sel,
  output riscv_ex_pkg::b_sel_t               b_sel,
  output logic [riscv_ex_pkg::XLEN-1:0]      imm
);

  localparam int XL = riscv_ex_pkg::XLEN;

  always_comb begin
    funcode = riscv_ex_pkg::ALU_NONE;
    a_sel   = riscv_ex_pkg::A_RS1;
    b_sel   = riscv_ex_pkg::B_RS2;
    imm     = '0;
    case (inst.r.opcode)
      riscv_isa_pkg::OP_OP: begin
        funcode = riscv_ex_pkg::alu_op_t'({inst.r.funct7[5], inst.r.funct3});
      end
      riscv_isa_pkg::OP_IMM: begin
        // Bit 30 only splits SRLI from SRAI.
        if (inst.i.funct3 == 3'b101) begin
          funcode = riscv_ex_pkg::alu_op_t'({inst.i.imm[10], inst.i.funct3});
        end else begin
          funcode = riscv_ex_pkg::alu_op_t'({1'b0, inst.i.funct3});
        end
        b_sel = riscv_ex_pkg::B_IMM;
        imm   = {{(XL-12){inst.i.imm[11]}}, inst.i.imm};
      end
      riscv_isa_pkg::OP_BRANCH: begin
        funcode = riscv_ex_pkg::ALU_SUB;
        imm     = {{(XL-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                   inst.b.imm_4_1, 1'b0};
      end
      riscv_isa_pkg::OP_LOAD, riscv_isa_pkg::OP_JALR: begin
        funcode = riscv_ex_pkg::ALU_ADD;
        imm     = {{(XL-12){inst.i.imm[11]}}, inst.i.imm};
        if (inst.i.opcode == riscv_isa_pkg::OP_JALR) begin
          a_sel = riscv_ex_pkg::A_PC;
          b_sel = riscv_ex_pkg::B_FOUR;
        end else begin
          b_sel = riscv_ex_pkg::B_IMM;
        end
      end
      riscv_isa_pkg::OP_STORE: begin
        funcode = riscv_ex_pkg::ALU_ADD;
        b_sel   = riscv_ex_pkg::B_IMM;
        imm     = {{(XL-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end
      riscv_isa_pkg::OP_LUI, riscv_isa_pkg::OP_AUIPC: begin
        funcode = riscv_ex_pkg::ALU_ADD;
        a_sel   = (inst.u.opcode == riscv_isa_pkg::OP_LUI) ? riscv_ex_pkg::A_ZERO
                                                           : riscv_ex_pkg::A_PC;
        b_sel   = riscv_ex_pkg::B_IMM;
        imm     = {inst.u.imm, 12'b0};
      end
      riscv_isa_pkg::OP_JAL: begin
        funcode = riscv_ex_pkg::ALU_ADD;
        a_sel   = riscv_ex_pkg::A_PC;
        b_sel   = riscv_ex_pkg::B_FOUR;
        imm     = {{(XL-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                   inst.j.imm_10_1, 1'b0};
      end
      default: begin
        // FENCE, SYSTEM and anything unknown give a zero result.
        funcode = riscv_ex_pkg::ALU_NONE;
      end
    endcase
  end

endmodule

//--- logic/riscv_ex_alu.sv
`timescale 1ns/1ps

module riscv_ex_alu (
  input  riscv_ex_pkg::alu_op_t              funcode,
  input  riscv_ex_pkg::a_sel_t               a_sel,
  input  riscv_ex_pkg::b_sel_t               b_sel,
  input  logic [riscv_ex_pkg::XLEN-1:0]      imm,
  input  logic [riscv_ex_pkg::XLEN-1:0]      pc,
  input  logic [riscv_ex_pkg::XLEN-1:0]      rs1,
  input  logic [riscv_ex_pkg::XLEN-1:0]      rs2,
  output logic [riscv_ex_pkg::XLEN-1:0]      result,
  output logic                               zero
);

  logic [riscv_ex_pkg::XLEN-1:0] op_a;
  logic [riscv_ex_pkg::XLEN-1:0] op_b;
  logic [4:0]                    shamt;

  // ==================
  // Operand select.
  // ==================
  always_comb begin
    case (a_sel)
      riscv_ex_pkg::A_PC:   op_a = pc;
      riscv_ex_pkg::A_ZERO: op_a = '0;
      default:              op_a = rs1;
    endcase
    case (b_sel)
      riscv_ex_pkg::B_IMM:  op_b = imm;
      riscv_ex_pkg::B_FOUR: op_b = riscv_ex_pkg::XLEN'(4);
      default:              op_b = rs2;
    endcase
  end

  assign shamt = op_b[4:0];

  // ==================
  // Function.
  // ==================
  always_comb begin
    case (funcode)
      riscv_ex_pkg::ALU_ADD:  result = op_a + op_b;
      riscv_ex_pkg::ALU_SUB:  result = op_a - op_b;
      riscv_ex_pkg::ALU_SLL:  result = op_a << shamt;
      riscv_ex_pkg::ALU_SLT:  result = riscv_ex_pkg::XLEN'($signed(op_a) < $signed(op_b));
      riscv_ex_pkg::ALU_SLTU: result = riscv_ex_pkg::XLEN'(op_a < op_b);
      riscv_ex_pkg::ALU_XOR:  result = op_a ^ op_b;
      riscv_ex_pkg::ALU_SRL:  result = op_a >> shamt;
      riscv_ex_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      riscv_ex_pkg::ALU_OR:   result = op_a | op_b;
      riscv_ex_pkg::ALU_AND:  result = op_a & op_b;
      default:                result = '0;
    endcase
  end

  // Branches read this flag from the subtraction.
  assign zero = (result == '0);

endmodule

//--- logic/riscv_ex_branch.sv
`timescale 1ns/1ps

module riscv_ex_branch (
  input  riscv_isa_pkg::inst_u               inst,
  input  logic [riscv_ex_pkg::XLEN-1:0]      pc,
  input  logic [riscv_ex_pkg::XLEN-1:0]      rs1,
  input  logic [riscv_ex_pkg::XLEN-1:0]      rs2,
  input  logic [riscv_ex_pkg::XLEN-1:0]      imm,
  output logic                               taken,
  output logic [riscv_ex_pkg::XLEN-1:0]      target
);

  logic                          eq;
  logic                          lt;
  logic                          ltu;
  logic [riscv_ex_pkg::XLEN-1:0] jalr_sum;

  assign eq       = (rs1 == rs2);
  assign lt       = ($signed(rs1) < $signed(rs2));
  assign ltu      = (rs1 < rs2);
  assign jalr_sum = rs1 + imm;

  always_comb begin
    taken  = 1'b0;
    target = '0;
    case (inst.b.opcode)
      riscv_isa_pkg::OP_BRANCH: begin
        case (inst.b.funct3)
          riscv_isa_pkg::F3_BEQ:  taken = eq;
          riscv_isa_pkg::F3_BNE:  taken = !eq;
          riscv_isa_pkg::F3_BLT:  taken = lt;
          riscv_isa_pkg::F3_BGE:  taken = !lt;
          riscv_isa_pkg::F3_BLTU: taken = ltu;
          riscv_isa_pkg::F3_BGEU: taken = !ltu;
          default:                taken = 1'b0;
        endcase
        target = pc + imm;
      end
      riscv_isa_pkg::OP_JAL: begin
        taken  = 1'b1;
        target = pc + imm;
      end
      riscv_isa_pkg::OP_JALR: begin
        // Low bit is cleared.
        taken  = 1'b1;
        target = {jalr_sum[riscv_ex_pkg::XLEN-1:1], 1'b0};
      end
      default: begin
        taken  = 1'b0;
        target = '0;
      end
    endcase
  end

endmodule

//--- logic/riscv_ex_queue.sv
`timescale 1ns/1ps

module riscv_ex_queue (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               push,
  input  riscv_isa_pkg::inst_u               push_inst,
  input  logic [riscv_ex_pkg::XLEN-1:0]      push_pc,
  input  logic [riscv_ex_pkg::XLEN-1:0]      push_rs1,
  input  logic [riscv_ex_pkg::XLEN-1:0]      push_rs2,
  input  logic                               pop,
  output logic                               head_valid,
  output riscv_isa_pkg::inst_u               head_inst,
  output logic [riscv_ex_pkg::XLEN-1:0]      head_pc,
  output logic [riscv_ex_pkg::XLEN-1:0]      head_rs1,
  output logic [riscv_ex_pkg::XLEN-1:0]      head_rs2,
  output logic                               credit
);

  localparam int DEPTH = riscv_ex_pkg::QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  riscv_isa_pkg::inst_u          mem_inst [DEPTH];
  logic [riscv_ex_pkg::XLEN-1:0] mem_pc   [DEPTH];
  logic [riscv_ex_pkg::XLEN-1:0] mem_rs1  [DEPTH];
  logic [riscv_ex_pkg::XLEN-1:0] mem_rs2  [DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [CNT_W-1:0]              count;

  // Storage.
  always_ff @(posedge clk) begin
    if (push) begin
      mem_inst[wr_ptr] <= push_inst;
      mem_pc[wr_ptr]   <= push_pc;
      mem_rs1[wr_ptr]  <= push_rs1;
      mem_rs2[wr_ptr]  <= push_rs2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back upstream per released entry.
      credit <= pop;
    end
  end

  assign head_valid = (count != '0);
  assign head_inst  = mem_inst[rd_ptr];
  assign head_pc    = mem_pc[rd_ptr];
  assign head_rs1   = mem_rs1[rd_ptr];
  assign head_rs2   = mem_rs2[rd_ptr];

endmodule

//--- logic/riscv_ex_stage.sv
`timescale 1ns/1ps

module riscv_ex_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  riscv_isa_pkg::inst_u               in_inst,
  input  logic [riscv_ex_pkg::XLEN-1:0]      in_pc,
  input  logic [riscv_ex_pkg::XLEN-1:0]      in_rs1,
  input  logic [riscv_ex_pkg::XLEN-1:0]      in_rs2,
  input  logic                               out_credit,
  output logic                               in_credit,
  output logic                               out_valid,
  output logic [riscv_ex_pkg::XLEN-1:0]      out_result,
  output logic                               out_zero,
  output logic                               out_taken,
  output logic [riscv_ex_pkg::XLEN-1:0]      out_target
);

  localparam int CRD_W = $clog2(riscv_ex_pkg::OUT_CREDITS + 1);

  logic                          head_valid;
  riscv_isa_pkg::inst_u          head_inst;
  logic [riscv_ex_pkg::XLEN-1:0] head_pc;
  logic [riscv_ex_pkg::XLEN-1:0] head_rs1;
  logic [riscv_ex_pkg::XLEN-1:0] head_rs2;
  logic                          pop;
  logic [CRD_W-1:0]              out_crd;

  riscv_ex_pkg::alu_op_t         funcode;
  riscv_ex_pkg::a_sel_t          a_sel;
  riscv_ex_pkg::b_sel_t          b_sel;
  logic [riscv_ex_pkg::XLEN-1:0] imm;
  logic [riscv_ex_pkg::XLEN-1:0] alu_result;
  logic                          alu_zero;
  logic                          br_taken;
  logic [riscv_ex_pkg::XLEN-1:0] br_target;

  // ==================
  // Instruction queue.
  // ==================
  riscv_ex_queue riscv_ex_queue_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (in_valid),
    .push_inst  (in_inst),
    .push_pc    (in_pc),
    .push_rs1   (in_rs1),
    .push_rs2   (in_rs2),
    .pop        (pop),
    .head_valid (head_valid),
    .head_inst  (head_inst),
    .head_pc    (head_pc),
    .head_rs1   (head_rs1),
    .head_rs2   (head_rs2),
    .credit     (in_credit)
  );

  // ==================
  // Execute on the head.
  // ==================
  riscv_ex_funcode riscv_ex_funcode_inst (
    .inst    (head_inst),
    .funcode (funcode),
    .a_sel   (a_sel),
    .b_sel   (b_sel),
    .imm     (imm)
  );

  riscv_ex_alu riscv_ex_alu_inst (
    .funcode (funcode),
    .a_sel   (a_sel),
    .b_sel   (b_sel),
    .imm     (imm),
    .pc      (head_pc),
    .rs1     (head_rs1),
    .rs2     (head_rs2),
    .result  (alu_result),
    .zero    (alu_zero)
  );

  riscv_ex_branch riscv_ex_branch_inst (
    .inst   (head_inst),
    .pc     (head_pc),
    .rs1    (head_rs1),
    .rs2    (head_rs2),
    .imm    (imm),
    .taken  (br_taken),
    .target (br_target)
  );

  // Pop only with a downstream credit in hand.
  assign pop = head_valid && (out_crd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_crd   <= CRD_W'(riscv_ex_pkg::OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      case ({pop, out_credit})
        2'b10:   out_crd <= out_crd - 1'b1;
        2'b01:   out_crd <= out_crd + 1'b1;
        default: out_crd <= out_crd;
      endcase
      out_valid <= pop;
    end
  end

  // Result registers.
  always_ff @(posedge clk) begin
    if (pop) begin
      out_result <= alu_result;
      out_zero   <= alu_zero;
      out_taken  <= br_taken;
      out_target <= br_target;
    end
  end

endmodule

//--- dv/riscv_ex_tests.svh
// ====================
// Instruction encoders.
// ====================
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
  return {f7, 5'd2, 5'd1, f3, 5'd3, riscv_isa_pkg::OP_OP};
endfunction

function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [11:0] imm);
  return {imm, 5'd1, f3, 5'd3, op};
endfunction

function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [11:0] imm);
  return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], riscv_isa_pkg::OP_STORE};
endfunction

function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [12:0] imm);
  return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], riscv_isa_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] u_word(input logic [6:0] op, input logic [19:0] imm);
  return {imm, 5'd3, op};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, riscv_isa_pkg::OP_JAL};
endfunction

// ====================
// Directed tests.
// ====================
task automatic reset_behavior();
  int first;
  int i;
  rst_n = 1'b0;
  for (i = 0; i < RESET_CYCLES; i++) begin
    tick();
    compare("out_valid in reset", 32'd0, 32'(out_valid));
    compare("in_credit in reset", 32'd0, 32'(in_credit));
  end
  rst_n = 1'b1;
  up_credits = riscv_ex_pkg::QUEUE_DEPTH;
  tick();
  tick();
  compare("out_valid after reset", 32'd0, 32'(out_valid));
  compare("in_credit pulses after reset", 32'd0, 32'(credit_pulses));
  // A full queue worth of instructions goes in on consecutive cycles.
  first = tick_no;
  for (i = 0; i < riscv_ex_pkg::QUEUE_DEPTH; i++) begin
    issue(r_word(7'h00, 3'd0), rand_pc(), rand_word(), rand_word(), "reset add");
  end
  drain();
  compare("first result latency", 32'd2, 32'(first_out_tick - first));
  compare("first in_credit latency", 32'd2, 32'(first_credit_tick - first));
endtask

task automatic alu_ops();
  int          rep;
  int          f;
  logic [11:0] imm;
  for (rep = 0; rep < 3; rep++) begin
    for (f = 0; f < 8; f++) begin
      issue(r_word(7'h00, 3'(f)), rand_pc(), rand_word(), rand_word(),
            $sformatf("op funct3 %0d", f));
    end
    issue(r_word(7'h20, 3'd0), rand_pc(), rand_word(), rand_word(), "sub");
    issue(r_word(7'h20, 3'd5), rand_pc(), rand_word(), rand_word(), "sra");
    for (f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) imm = {7'h00, 5'(rand_bits(5))};
      else imm = 12'(rand_bits(12));
      issue(i_word(riscv_isa_pkg::OP_IMM, 3'(f), imm), rand_pc(), rand_word(), rand_word(),
            $sformatf("op_imm funct3 %0d", f));
    end
    issue(i_word(riscv_isa_pkg::OP_IMM, 3'd5, {7'h20, 5'(rand_bits(5))}), rand_pc(),
          rand_word(), rand_word(), "srai");
  end
  issue(r_word(7'h20, 3'd5), rand_pc(), 32'hF000_1234, 32'd4, "sra negative");
  issue(r_word(7'h00, 3'd5), rand_pc(), 32'hF000_1234, 32'd4, "srl negative");
  issue(r_word(7'h00, 3'd2), rand_pc(), 32'hFFFF_FFF0, 32'd5, "slt signed");
  issue(r_word(7'h00, 3'd3), rand_pc(), 32'hFFFF_FFF0, 32'd5, "sltu unsigned");
  imm = 12'h400;
  issue(i_word(riscv_isa_pkg::OP_IMM, 3'd0, imm), rand_pc(), rand_word(), 32'd0,
        "addi with bit 30 set");
  issue(r_word(7'h20, 3'd0), rand_pc(), 32'h1234_5678, 32'h1234_5678, "sub equal");
  drain();
endtask

task automatic upper_and_jump();
  int rep;
  for (rep = 0; rep < 2; rep++) begin
    issue(u_word(riscv_isa_pkg::OP_LUI, 20'(rand_bits(20))), rand_pc(), rand_word(),
          rand_word(), "lui");
    issue(u_word(riscv_isa_pkg::OP_AUIPC, 20'(rand_bits(20))), rand_pc(), rand_word(),
          rand_word(), "auipc");
    issue(j_word({20'(rand_bits(20)), 1'b0}), rand_pc(), rand_word(), rand_word(), "jal");
    issue(i_word(riscv_isa_pkg::OP_JALR, 3'd0, 12'(rand_bits(12))), rand_pc(), rand_word(),
          rand_word(), "jalr");
    issue(i_word(riscv_isa_pkg::OP_LOAD, 3'd2, 12'(rand_bits(12))), rand_pc(), rand_word(),
          rand_word(), "load");
    issue(s_word(3'd2, 12'(rand_bits(12))), rand_pc(), rand_word(), rand_word(), "store");
  end
  drain();
endtask

task automatic branch_conditions();
  logic [2:0]  conds [6];
  logic [31:0] lhs [5];
  logic [31:0] rhs [5];
  logic [31:0] same;
  int          c;
  int          p;
  conds = '{riscv_isa_pkg::F3_BEQ, riscv_isa_pkg::F3_BNE, riscv_isa_pkg::F3_BLT,
            riscv_isa_pkg::F3_BGE, riscv_isa_pkg::F3_BLTU, riscv_isa_pkg::F3_BGEU};
  same = rand_word();
  // Equal, signed less but unsigned greater, the reverse, then plain less and greater.
  lhs = '{same, 32'h8000_0010, 32'h0000_0020, 32'h0000_0100, 32'hFFFF_FF00};
  rhs = '{same, 32'h0000_0020, 32'h8000_0010, 32'h0000_0200, 32'hFFFF_0000};
  for (c = 0; c < 6; c++) begin
    for (p = 0; p < 5; p++) begin
      issue(b_word(conds[c], {12'(rand_bits(12)), 1'b0}), rand_pc(), lhs[p], rhs[p],
            $sformatf("branch funct3 %0d pair %0d", conds[c], p));
    end
  end
  drain();
endtask

task automatic back_pressure();
  int seen0;
  int pulses0;
  int i;
  return_credits = 1'b0;
  seen0   = results_seen;
  pulses0 = credit_pulses;
  for (i = 0; i < riscv_ex_pkg::QUEUE_DEPTH + riscv_ex_pkg::OUT_CREDITS; i++) begin
    issue(i_word(riscv_isa_pkg::OP_IMM, 3'd0, 12'(i + 1)), rand_pc(), rand_word(), 32'd0,
          $sformatf("ordered addi %0d", i));
  end
  repeat (10) tick();
  compare("results without credit return", 32'(riscv_ex_pkg::OUT_CREDITS),
          32'(results_seen - seen0));
  compare("in_credit pulses without credit return", 32'(riscv_ex_pkg::OUT_CREDITS),
          32'(credit_pulses - pulses0));
  compare("upstream credits left", 32'd0, 32'(up_credits));
  // Remaining results must now come out in issue order.
  drain();
endtask

task automatic fence_and_system();
  issue({25'(rand_bits(25)), riscv_isa_pkg::OP_FENCE}, rand_pc(), rand_word(), rand_word(),
        "fence");
  issue({25'(rand_bits(25)), riscv_isa_pkg::OP_SYS}, rand_pc(), rand_word(), rand_word(),
        "system");
  drain();
endtask

//--- dv/riscv_ex_tb.sv
`timescale 1ns/1ps

module riscv_ex_tb;

  localparam int RESET_CYCLES = 16;
  // Instructions issued over all directed tests.
  localparam int TOTAL_INSTR  = 117;
  localparam int CYCLE_LIMIT  = 4 * TOTAL_INSTR + RESET_CYCLES;
  localparam logic [15:0] SEED = 16'd29099;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  riscv_isa_pkg::inst_u in_inst;
  logic [31:0]          in_pc;
  logic [31:0]          in_rs1;
  logic [31:0]          in_rs2;
  logic                 out_credit;
  logic                 in_credit;
  logic                 out_valid;
  logic [31:0]          out_result;
  logic                 out_zero;
  logic                 out_taken;
  logic [31:0]          out_target;

  logic [15:0] lfsr;
  int          cycle_cnt = 0;
  int          tick_no = 0;
  int          first_out_tick = -1;
  int          first_credit_tick = -1;
  int          up_credits = 0;
  int          credit_pulses = 0;
  int          results_seen = 0;
  int          owed = 0;
  logic        return_credits = 1'b1;

  // Expected results in issue order.
  logic [31:0] exp_res[$];
  logic        exp_zero[$];
  logic        exp_taken[$];
  logic [31:0] exp_target[$];
  string       exp_name[$];

  riscv_ex_stage riscv_ex_stage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_inst    (in_inst),
    .in_pc      (in_pc),
    .in_rs1     (in_rs1),
    .in_rs2     (in_rs2),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_zero   (out_zero),
    .out_taken  (out_taken),
    .out_target (out_target)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort($sformatf("timeout: the run did not end within %0d cycles", CYCLE_LIMIT));
    end
  end

  // ====================
  // Failure handling.
  // ====================
  task automatic abort(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      abort($sformatf("error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // ====================
  // Random stimulus.
  // ====================
  // Taps 16, 14, 13, 11.
  function logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    repeat (n) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic logic [31:0] rand_word();
    return rand_bits(32);
  endfunction

  function automatic logic [31:0] rand_pc();
    return rand_bits(30) << 2;
  endfunction

  // ====================
  // Reference model.
  // ====================
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [31:0]        r;
    sa = a;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = sa >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic predict(input logic [31:0] w, input logic [31:0] pc,
                         input logic [31:0] a, input logic [31:0] b,
                         output logic [31:0] res, output logic z,
                         output logic tk, output logic [31:0] tgt);
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    res = '0;
    tk  = 1'b0;
    tgt = '0;
    case (w[6:0])
      riscv_isa_pkg::OP_OP:    res = alu_model(f3, w[30], a, b);
      riscv_isa_pkg::OP_IMM:   res = alu_model(f3, (f3 == 3'd5) && w[30], a, imm_i);
      riscv_isa_pkg::OP_LUI:   res = imm_u;
      riscv_isa_pkg::OP_AUIPC: res = pc + imm_u;
      riscv_isa_pkg::OP_LOAD:  res = a + imm_i;
      riscv_isa_pkg::OP_STORE: res = a + imm_s;
      riscv_isa_pkg::OP_JAL: begin
        res = pc + 32'd4;
        tk  = 1'b1;
        tgt = pc + imm_j;
      end
      riscv_isa_pkg::OP_JALR: begin
        res = pc + 32'd4;
        tk  = 1'b1;
        tgt = (a + imm_i) & ~32'd1;
      end
      riscv_isa_pkg::OP_BRANCH: begin
        res = a - b;
        tk  = branch_model(f3, a, b);
        tgt = pc + imm_b;
      end
      default: res = '0;
    endcase
    z = (res == '0);
  endtask

  // ====================
  // Upstream and downstream agents.
  // ====================
  task automatic tick();
    string nm;
    @(negedge clk);
    tick_no++;
    in_valid = 1'b0;
    if (in_credit) begin
      up_credits++;
      credit_pulses++;
      if (first_credit_tick < 0) first_credit_tick = tick_no;
    end
    if (out_valid) begin
      if (exp_res.size() == 0) begin
        abort("out_valid rose with no instruction outstanding");
      end
      if (first_out_tick < 0) first_out_tick = tick_no;
      nm = exp_name.pop_front();
      compare({nm, " result"}, exp_res.pop_front(), out_result);
      compare({nm, " zero"}, 32'(exp_zero.pop_front()), 32'(out_zero));
      compare({nm, " taken"}, 32'(exp_taken.pop_front()), 32'(out_taken));
      compare({nm, " target"}, exp_target.pop_front(), out_target);
      results_seen++;
      owed++;
    end
    if (return_credits && owed > 0) begin
      out_credit = 1'b1;
      owed--;
    end else begin
      out_credit = 1'b0;
    end
  endtask

  task automatic issue(input logic [31:0] word, input logic [31:0] pc,
                       input logic [31:0] a, input logic [31:0] b, input string name);
    logic [31:0] res;
    logic        z;
    logic        tk;
    logic [31:0] tgt;
    while (up_credits == 0) tick();
    predict(word, pc, a, b, res, z, tk, tgt);
    exp_res.push_back(res);
    exp_zero.push_back(z);
    exp_taken.push_back(tk);
    exp_target.push_back(tgt);
    exp_name.push_back(name);
    in_valid = 1'b1;
    in_inst  = word;
    in_pc    = pc;
    in_rs1   = a;
    in_rs2   = b;
    up_credits--;
    tick();
  endtask

  task automatic drain();
    return_credits = 1'b1;
    while (exp_res.size() != 0 || owed != 0) tick();
  endtask

  `include "riscv_ex_tests.svh"

  initial begin
    in_valid   = 1'b0;
    in_inst    = '0;
    in_pc      = '0;
    in_rs1     = '0;
    in_rs2     = '0;
    out_credit = 1'b0;
    rst_n      = 1'b0;
    lfsr       = SEED;
    reset_behavior();
    alu_ops();
    upper_and_jump();
    branch_conditions();
    back_pressure();
    fence_and_system();
    if (exp_res.size() == 0 && up_credits == riscv_ex_pkg::QUEUE_DEPTH) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort("results or upstream credits were left outstanding at the end of the run");
    end
  end

endmodule

//--- riscv_ex.f
+incdir+dv
logic/riscv_isa_pkg.sv
logic/riscv_ex_pkg.sv
logic/riscv_ex_funcode.sv
logic/riscv_ex_alu.sv
logic/riscv_ex_branch.sv
logic/riscv_ex_queue.sv
logic/riscv_ex_stage.sv
dv/riscv_ex_tb.sv

//--- Makefile
TOP = riscv_ex_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f riscv_ex.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module riscv_ex_stage -f riscv_ex.f

clean:
	rm -rf obj_dir
